//--- pool_defines.svh
`ifndef POOL_DEFINES_SVH
`define POOL_DEFINES_SVH

////////////////////////////////////////////////////////////
// Pixel format
////////////////////////////////////////////////////////////

// Channels carried side by side per pixel position
`define CI          3

// Bits per signed channel value
`define IF_BW       16

////////////////////////////////////////////////////////////
// Frame and pooling geometry
////////////////////////////////////////////////////////////

// Frame size in pixels with both sides even
`define IMG_W       8
`define IMG_H       6

// Only a pooling window side of 2 is supported
`define POOL_K      2

// Entries in the stream FIFO array without the output slot
`define FIFO_DEPTH  4

`endif

//--- cnn_pool_pkg.sv
`include "pool_defines.svh"

package cnn_pool_pkg;

    // One signed channel value
    typedef logic signed [`IF_BW-1:0] pixel_t;

    // All channels of one pixel position with channel 0 in the low bits
    typedef pixel_t [`CI-1:0] pixel_vec_t;

endpackage

//--- pixel_stream_if.sv
`include "pool_defines.svh"

interface pixel_stream_if (
    input logic clk
);

    // Handshake pair that transfers when both are high at a rising edge
    logic                     valid;
    logic                     ready;

    // Payload held stable while valid is high and ready is low
    cnn_pool_pkg::pixel_vec_t data;

    // Sending side of a link
    modport src (
        input  clk,
        output valid,
        output data,
        input  ready
    );

    // Receiving side of a link
    modport dst (
        input  clk,
        input  valid,
        input  data,
        output ready
    );

endinterface

//--- relu_stage.sv
`include "pool_defines.svh"

module relu_stage (
    input  logic                     clk,
    input  logic                     reset_n,

    input  logic                     i_in_valid,
    input  cnn_pool_pkg::pixel_vec_t i_in_pixel,
    output logic                     o_in_ready,

    pixel_stream_if.src              o_out
);

    logic                     out_valid;
    cnn_pool_pkg::pixel_vec_t out_data;
    cnn_pool_pkg::pixel_vec_t relu_data;
    logic                     accept;

    ////////////////////////////////////////////////////////////
    // Rectifier
    ////////////////////////////////////////////////////////////

    // Sign bit turns a negative channel into zero
    always_comb begin
        for (int c = 0; c < `CI; c++) begin
            if (i_in_pixel[c][`IF_BW-1]) begin
                relu_data[c] = '0;
            end else begin
                relu_data[c] = i_in_pixel[c];
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Single output slot
    ////////////////////////////////////////////////////////////

    // Slot can take a new vector when empty or being drained now
    assign o_in_ready = !out_valid || o_out.ready;
    assign accept     = i_in_valid && o_in_ready;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            out_valid <= 1'b0;
        end else if (o_in_ready) begin
            out_valid <= i_in_valid;
        end
    end

    // Payload register
    always_ff @(posedge clk) begin
        if (accept) begin
            out_data <= relu_data;
        end
    end

    assign o_out.valid = out_valid;
    assign o_out.data  = out_data;

endmodule

//--- stream_fifo.sv
`include "pool_defines.svh"

module stream_fifo (
    input  logic         clk,
    input  logic         reset_n,

    pixel_stream_if.dst  i_wr,
    pixel_stream_if.src  o_rd
);

    localparam int AW = $clog2(`FIFO_DEPTH);
    localparam logic [AW:0]   DEPTH    = (AW + 1)'(`FIFO_DEPTH);
    localparam logic [AW-1:0] PTR_LAST = AW'(`FIFO_DEPTH - 1);

    cnn_pool_pkg::pixel_vec_t mem [`FIFO_DEPTH];

    logic [AW-1:0]            wr_ptr;
    logic [AW-1:0]            rd_ptr;
    logic [AW:0]              count;
    logic                     push;
    logic                     load;
    logic                     out_valid;
    cnn_pool_pkg::pixel_vec_t out_data;

    ////////////////////////////////////////////////////////////
    // Handshake decode
    ////////////////////////////////////////////////////////////

    // Move head of the array into the slot when the slot frees up
    assign load = (count != '0) && (!out_valid || o_rd.ready);

    // A full array still accepts if its head leaves in this cycle
    assign i_wr.ready = (count != DEPTH) || load;
    assign push       = i_wr.valid && i_wr.ready;

    ////////////////////////////////////////////////////////////
    // Pointers and occupancy
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
            end
            if (load) begin
                rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, load})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Storage array
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= i_wr.data;
        end
    end

    ////////////////////////////////////////////////////////////
    // Registered read slot
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            out_valid <= 1'b0;
        end else if (load) begin
            out_valid <= 1'b1;
        end else if (o_rd.ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            out_data <= mem[rd_ptr];
        end
    end

    assign o_rd.valid = out_valid;
    assign o_rd.data  = out_data;

endmodule

//--- max_pooling.sv
`include "pool_defines.svh"

module max_pooling (
    input  logic                     clk,
    input  logic                     reset_n,

    pixel_stream_if.dst              i_in,

    output logic                     o_pool_valid,
    output cnn_pool_pkg::pixel_vec_t o_pool_data,
    output logic                     o_pool_last,
    input  logic                     i_pool_ready
);

    localparam int CW     = $clog2(`IMG_W);
    localparam int RW     = $clog2(`IMG_H);
    localparam int LINE_N = `IMG_W / `POOL_K;

    localparam logic [CW-1:0] COL_LAST = CW'(`IMG_W - 1);
    localparam logic [RW-1:0] ROW_LAST = RW'(`IMG_H - 1);

    // Half-row of horizontal pair maxima from the even row
    cnn_pool_pkg::pixel_vec_t line_mem [LINE_N];

    logic [CW-1:0]            col;
    logic [RW-1:0]            row;
    logic                     col_last;
    logic                     row_last;
    logic                     accept;
    logic                     odd_col;
    logic                     odd_row;
    logic [CW-2:0]            pair_idx;
    cnn_pool_pkg::pixel_vec_t left_pixel;
    cnn_pool_pkg::pixel_vec_t pair_max;
    cnn_pool_pkg::pixel_vec_t block_max;
    logic                     block_done;

    // Channel-wise signed maximum of two vectors
    function automatic cnn_pool_pkg::pixel_vec_t vec_max(
        input cnn_pool_pkg::pixel_vec_t a,
        input cnn_pool_pkg::pixel_vec_t b
    );
        cnn_pool_pkg::pixel_vec_t m;
        for (int c = 0; c < `CI; c++) begin
            m[c] = ($signed(a[c]) > $signed(b[c])) ? a[c] : b[c];
        end
        return m;
    endfunction

    ////////////////////////////////////////////////////////////
    // Raster position
    ////////////////////////////////////////////////////////////

    // Stall input only while a pooled result waits downstream
    assign i_in.ready = !o_pool_valid || i_pool_ready;
    assign accept     = i_in.valid && i_in.ready;

    assign col_last = (col == COL_LAST);
    assign row_last = (row == ROW_LAST);
    assign odd_col  = col[0];
    assign odd_row  = row[0];
    assign pair_idx = col[CW-1:1];

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            col <= '0;
            row <= '0;
        end else if (accept) begin
            if (col_last) begin
                col <= '0;
                row <= row_last ? '0 : row + 1'b1;
            end else begin
                col <= col + 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Pair and block maxima
    ////////////////////////////////////////////////////////////

    assign pair_max   = vec_max(left_pixel, i_in.data);
    assign block_max  = vec_max(line_mem[pair_idx], pair_max);
    assign block_done = accept && odd_col && odd_row;

    // Left half of the pair, then the even-row line buffer
    always_ff @(posedge clk) begin
        if (accept && !odd_col) begin
            left_pixel <= i_in.data;
        end
        if (accept && odd_col && !odd_row) begin
            line_mem[pair_idx] <= pair_max;
        end
    end

    ////////////////////////////////////////////////////////////
    // Output register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            o_pool_valid <= 1'b0;
            o_pool_last  <= 1'b0;
        end else if (block_done) begin
            o_pool_valid <= 1'b1;
            // Bottom-right block closes the frame
            o_pool_last  <= col_last && row_last;
        end else if (i_pool_ready) begin
            o_pool_valid <= 1'b0;
            o_pool_last  <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (block_done) begin
            o_pool_data <= block_max;
        end
    end

endmodule

//--- cnn_pool_top.sv
`include "pool_defines.svh"

module cnn_pool_top (
    input  logic                     clk,
    input  logic                     reset_n,

    // Raster pixel input
    input  logic                     i_in_valid,
    input  cnn_pool_pkg::pixel_vec_t i_in_pixel,
    output logic                     o_in_ready,

    // Pooled output with one vector per 2x2 block
    output logic                     o_pool_valid,
    output cnn_pool_pkg::pixel_vec_t o_pool_data,
    output logic                     o_pool_last,
    input  logic                     i_pool_ready
);

    ////////////////////////////////////////////////////////////
    // Internal links
    ////////////////////////////////////////////////////////////

    pixel_stream_if relu_to_fifo (.clk(clk));
    pixel_stream_if fifo_to_pool (.clk(clk));

    ////////////////////////////////////////////////////////////
    // Pipeline stages
    ////////////////////////////////////////////////////////////

    // ReLU and input register
    relu_stage u_relu (
        .clk        (clk),
        .reset_n    (reset_n),
        .i_in_valid (i_in_valid),
        .i_in_pixel (i_in_pixel),
        .o_in_ready (o_in_ready),
        .o_out      (relu_to_fifo.src)
    );

    // Elastic buffer between the stages
    stream_fifo u_fifo (
        .clk     (clk),
        .reset_n (reset_n),
        .i_wr    (relu_to_fifo.dst),
        .o_rd    (fifo_to_pool.src)
    );

    // 2x2 stride 2 max pooling
    max_pooling u_pool (
        .clk          (clk),
        .reset_n      (reset_n),
        .i_in         (fifo_to_pool.dst),
        .o_pool_valid (o_pool_valid),
        .o_pool_data  (o_pool_data),
        .o_pool_last  (o_pool_last),
        .i_pool_ready (i_pool_ready)
    );

endmodule

//--- tb_clock_gen.sv
module tb_clock_gen (
    output logic clk,
    output logic reset_n
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESET_CYCLES = 3;

    // 20 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    // Falling edge at 1 ns fires the async resets and release follows three rising edges
    initial begin
        reset_n = 1'b1;
        #1 reset_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 reset_n = 1'b1;
    end

endmodule

//--- cnn_pool_properties.sv
`include "pool_defines.svh"

module cnn_pool_properties (
    input logic                         clk,
    input logic                         reset_n,
    input logic                         i_pool_valid,
    input cnn_pool_pkg::pixel_vec_t     i_pool_data,
    input logic                         i_pool_last,
    input logic                         i_pool_ready,
    input logic [$clog2(`FIFO_DEPTH):0] i_fifo_count
);

    timeunit 1ns;
    timeprecision 1ps;

    // Count of failed assertions
    int assert_errors = 0;

    // Stalled output keeps its vector and marker
    a_hold_stable: assert property (
        @(posedge clk) disable iff (!reset_n)
        i_pool_valid && !i_pool_ready |=>
            i_pool_valid && $stable(i_pool_data) && $stable(i_pool_last)
    ) else begin
        assert_errors++;
        $error("pooled output changed while i_pool_ready was low");
    end

    a_reset_idle: assert property (@(posedge clk) !reset_n |-> !i_pool_valid) else begin
        assert_errors++;
        $error("o_pool_valid high during reset");
    end

    a_fifo_bound: assert property (
        @(posedge clk) disable iff (!reset_n) i_fifo_count <= `FIFO_DEPTH
    ) else begin
        assert_errors++;
        $error("FIFO occupancy above its depth");
    end

endmodule

bind cnn_pool_top cnn_pool_properties i_props (
    .clk          (clk),
    .reset_n      (reset_n),
    .i_pool_valid (o_pool_valid),
    .i_pool_data  (o_pool_data),
    .i_pool_last  (o_pool_last),
    .i_pool_ready (i_pool_ready),
    .i_fifo_count (u_fifo.count)
);

//--- cnn_pool_tb.sv
`include "pool_defines.svh"

module cnn_pool_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int BLOCKS_W     = `IMG_W / 2;
    localparam int BLOCKS_H     = `IMG_H / 2;
    localparam int NUM_TESTS    = 6;
    localparam int IDLE_LIMIT   = 200;
    localparam int RESET_LIMIT  = 100;
    localparam int DRAIN_CYCLES = 30;

    typedef enum int {MODE_RANDOM, MODE_NEGATIVE, MODE_RAMP} pixel_mode_t;

    typedef struct {
        string       name;
        pixel_mode_t mode;
        int          gap_pct;
        int          stall_pct;
    } test_entry_t;

    logic                     clk;
    logic                     reset_n;
    logic                     in_valid;
    cnn_pool_pkg::pixel_vec_t in_pixel;
    logic                     in_ready;
    logic                     pool_valid;
    cnn_pool_pkg::pixel_vec_t pool_data;
    logic                     pool_last;
    logic                     pool_ready;

    test_entry_t tests [NUM_TESTS];
    logic [31:0] lfsr_state;

    // Input pixels and expected pooled vectors tagged with their test index
    cnn_pool_pkg::pixel_vec_t in_q[$];
    int                       in_test_q[$];
    cnn_pool_pkg::pixel_vec_t exp_q[$];
    logic                     exp_last_q[$];
    int                       exp_test_q[$];

    tb_clock_gen u_clock_gen (.clk(clk), .reset_n(reset_n));

    cnn_pool_top i_cnn_pool_top (
        .clk          (clk),
        .reset_n      (reset_n),
        .i_in_valid   (in_valid),
        .i_in_pixel   (in_pixel),
        .o_in_ready   (in_ready),
        .o_pool_valid (pool_valid),
        .o_pool_data  (pool_data),
        .o_pool_last  (pool_last),
        .i_pool_ready (pool_ready)
    );

    // Galois step with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h80200003;
        end
        return s >> 1;
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    function automatic logic chance(input int pct);
        return int'(take_bits(7) % 100) < pct;
    endfunction

    function automatic cnn_pool_pkg::pixel_t relu(input cnn_pool_pkg::pixel_t v);
        return (v < 0) ? '0 : v;
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("SOME TESTS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            abort_run($sformatf("CHECK FAILED %s expected %h actual %h",
                                name, expected, actual));
        end
    endtask

    // Stop at the first failed assertion of the bound checker
    always @(i_cnn_pool_top.i_props.assert_errors) begin
        if (i_cnn_pool_top.i_props.assert_errors != 0) begin
            abort_run("A bound assertion on the DUT failed");
        end
    end

    // One frame of input pixels plus its reference pooled outputs
    task automatic build_frame(input int t);
        cnn_pool_pkg::pixel_vec_t frame [`IMG_H][`IMG_W];
        cnn_pool_pkg::pixel_vec_t best;
        cnn_pool_pkg::pixel_t     v;
        for (int r = 0; r < `IMG_H; r++) begin
            for (int c = 0; c < `IMG_W; c++) begin
                for (int ch = 0; ch < `CI; ch++) begin
                    case (tests[t].mode)
                        MODE_RANDOM: frame[r][c][ch] =
                            cnn_pool_pkg::pixel_t'(take_bits(`IF_BW));
                        MODE_NEGATIVE: frame[r][c][ch] = cnn_pool_pkg::pixel_t'(
                            take_bits(`IF_BW - 1) | (32'd1 << (`IF_BW - 1)));
                        default: frame[r][c][ch] =
                            cnn_pool_pkg::pixel_t'((r * `IMG_W + c) * 4 + ch);
                    endcase
                end
                in_q.push_back(frame[r][c]);
                in_test_q.push_back(t);
            end
        end
        for (int br = 0; br < BLOCKS_H; br++) begin
            for (int bc = 0; bc < BLOCKS_W; bc++) begin
                best = '0;
                for (int k = 0; k < 4; k++) begin
                    for (int ch = 0; ch < `CI; ch++) begin
                        v = relu(frame[2 * br + k / 2][2 * bc + k % 2][ch]);
                        if (v > best[ch]) begin
                            best[ch] = v;
                        end
                    end
                end
                exp_q.push_back(best);
                exp_last_q.push_back(br == BLOCKS_H - 1 && bc == BLOCKS_W - 1);
                exp_test_q.push_back(t);
            end
        end
    endtask

    task automatic wait_reset_release();
        int steps;
        steps = 0;
        while (reset_n !== 1'b0) begin
            #1;
            steps++;
            if (steps > RESET_LIMIT) begin
                abort_run("Timeout: reset was never asserted");
            end
        end
        steps = 0;
        while (reset_n !== 1'b1) begin
            @(posedge clk);
            steps++;
            if (steps > RESET_LIMIT) begin
                abort_run("Timeout: reset was never released");
            end
        end
    endtask

    task automatic compare_output();
        string name;
        name = tests[exp_test_q[0]].name;
        check_value({name, " data"}, 64'(exp_q[0]), 64'(pool_data));
        check_value({name, " last"}, 64'(exp_last_q[0]), 64'(pool_last));
        void'(exp_q.pop_front());
        void'(exp_last_q.pop_front());
        void'(exp_test_q.pop_front());
    endtask

    initial begin
        logic held;
        logic in_fire;
        int   idle;

        in_valid   = 1'b0;
        in_pixel   = '0;
        pool_ready = 1'b0;
        lfsr_state = 32'h6563680b;
        held       = 1'b0;
        idle       = 0;

        // name, pixel mode, input gap percent, output stall percent
        tests[0] = '{"random_flat",        MODE_RANDOM,   0,  0};
        tests[1] = '{"all_negative",       MODE_NEGATIVE, 0,  0};
        tests[2] = '{"ramp",               MODE_RAMP,     0,  0};
        tests[3] = '{"random_gaps_stalls", MODE_RANDOM,   30, 40};
        tests[4] = '{"ramp_stalls",        MODE_RAMP,     10, 70};
        tests[5] = '{"random_gaps",        MODE_RANDOM,   60, 15};
        for (int t = 0; t < NUM_TESTS; t++) begin
            build_frame(t);
        end

        wait_reset_release();
        @(negedge clk);
        check_value("reset o_pool_valid", 64'(0), 64'(pool_valid));
        check_value("reset o_pool_last", 64'(0), 64'(pool_last));
        check_value("reset o_in_ready", 64'(1), 64'(in_ready));

        // Frames stream back to back with handshakes sampled at the falling edge
        while (exp_q.size() != 0) begin
            @(posedge clk);
            #1;
            if (in_q.size() == 0) begin
                in_valid = 1'b0;
            end else begin
                if (!held) begin
                    in_valid = !chance(tests[in_test_q[0]].gap_pct);
                end
                in_pixel = in_q[0];
            end
            pool_ready = !chance(tests[exp_test_q[0]].stall_pct);
            @(negedge clk);
            in_fire = in_valid && in_ready;
            held    = in_valid && !in_ready;
            idle    = idle + 1;
            if (in_fire) begin
                void'(in_q.pop_front());
                void'(in_test_q.pop_front());
                idle = 0;
            end
            if (pool_valid && pool_ready) begin
                compare_output();
                idle = 0;
            end
            if (idle > IDLE_LIMIT) begin
                abort_run($sformatf("Timeout: no handshake for %0d cycles", IDLE_LIMIT));
            end
        end

        // Nothing may follow the last expected output
        @(posedge clk);
        #1;
        in_valid   = 1'b0;
        pool_ready = 1'b1;
        repeat (DRAIN_CYCLES) begin
            @(negedge clk);
            if (pool_valid) begin
                abort_run("Extra pooled output after the expected sequence");
            end
        end

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

//--- sources.f
+incdir+.
cnn_pool_pkg.sv
pixel_stream_if.sv
relu_stage.sv
stream_fifo.sv
max_pooling.sv
cnn_pool_top.sv
tb_clock_gen.sv
cnn_pool_properties.sv
cnn_pool_tb.sv

//--- Bender.yml
package:
  name: cnn_pool

sources:
  - include_dirs:
      - .
    files:
      - cnn_pool_pkg.sv
      - pixel_stream_if.sv
      - relu_stage.sv
      - stream_fifo.sv
      - max_pooling.sv
      - cnn_pool_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_clock_gen.sv
      - cnn_pool_properties.sv
      - cnn_pool_tb.sv
